// ==== mem_pkg.sv ====
/*
 * Shared definitions for the data-side memory subsystem
 *   - address, data, length and byte enable types
 *   - burst opcode and the FSM state encodings
 *   - MAX_BURST and the words_spanned helper
 */

package mem_pkg;

    localparam int MAX_BURST = 3;              // words in the longest burst

    typedef logic [31:0] addr_t;               // byte address
    typedef logic [29:0] word_addr_t;          // avalon word address
    typedef logic [31:0] dword_t;
    typedef logic [3:0]  byteen_t;
    typedef logic [3:0]  read_len_t;           // 1..8 bytes
    typedef logic [2:0]  write_len_t;          // 1..4 bytes
    typedef logic [63:0] read_data_t;
    typedef logic [1:0]  burst_cnt_t;          // 1..3 words
    typedef logic [MAX_BURST*32-1:0] burst_data_t;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } burst_op_t;

    typedef enum logic [1:0] {s_idle, s_wait, s_done} split_state_t;

    typedef enum logic [1:0] {a_idle, a_write, a_read_cmd, a_read_data} avm_state_t;

    // --------------------
    // number of bus words touched by len bytes starting at addr
    function automatic burst_cnt_t words_spanned(input addr_t addr, input read_len_t len);
        logic [4:0] last_byte;
        last_byte = 5'(addr[1:0]) + 5'(len) - 5'd1;     // offset of last byte
        return burst_cnt_t'(last_byte[4:2]) + 2'd1;
    endfunction

endpackage

// ==== burst_if.sv ====
/*
 * Burst command and response link between the internal blocks
 *   - burst_do / burst_done handshake
 *   - opcode, word address, count, edge byte enables, write data
 *   - read data returned with burst_done
 */

`timescale 1ns/10ps

interface burst_if import mem_pkg::*; ();

    logic        burst_do;           // held until burst_done
    logic        burst_done;         // one cycle pulse
    burst_op_t   op;
    word_addr_t  address;
    burst_cnt_t  count;
    byteen_t     byteen_first;
    byteen_t     byteen_last;
    burst_data_t wdata;              // word 0 in the low bits
    burst_data_t rdata;              // valid with burst_done

    modport requester (
        output burst_do, op, address, count, byteen_first, byteen_last, wdata,
        input  burst_done, rdata
    );

    modport responder (
        input  burst_do, op, address, count, byteen_first, byteen_last, wdata,
        output burst_done, rdata
    );

endinterface

// ==== mem_access_split.sv ====
/*
 * Requester front end of the memory subsystem
 *   - arbitration between the read and write ports
 *   - split of a byte request into a word burst
 *   - right alignment and length masking of read data
 */

`timescale 1ns/10ps

module mem_access_split import mem_pkg::*; #(
    parameter bit WRITE_PRIORITY = 1'b1
) (
    input  logic        clk,
    input  logic        reset,

    input  logic        read_do,
    input  addr_t       read_addr,
    input  read_len_t   read_len,
    output logic        read_done,
    output read_data_t  read_data,

    input  logic        write_do,
    input  addr_t       write_addr,
    input  write_len_t  write_len,
    input  dword_t      write_data,
    output logic        write_done,

    burst_if.requester  bus
);

    split_state_t state;
    logic         pick_write;
    addr_t        sel_addr;
    read_len_t    sel_len;
    burst_cnt_t   sel_cnt;
    logic [11:0]  be_mask;
    byteen_t      sel_be_last;

    burst_op_t    op_r;
    word_addr_t   waddr_r;
    burst_cnt_t   cnt_r;
    byteen_t      be_first_r;
    byteen_t      be_last_r;
    burst_data_t  wdata_r;
    logic [1:0]   off_r;
    read_len_t    len_r;

    burst_data_t  shifted;
    read_data_t   len_mask;

    // --------------------
    // request select and split

    assign pick_write = write_do && (WRITE_PRIORITY || !read_do);
    assign sel_addr   = pick_write ? write_addr : read_addr;
    assign sel_len    = pick_write ? {1'b0, write_len} : read_len;
    assign sel_cnt    = words_spanned(sel_addr, sel_len);
    assign be_mask    = ((12'd1 << sel_len) - 12'd1) << sel_addr[1:0];

    always_comb begin
        case (sel_cnt)
            2'd3:    sel_be_last = be_mask[11:8];
            2'd2:    sel_be_last = be_mask[7:4];
            default: sel_be_last = be_mask[3:0];
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle:  if (read_do || write_do) state <= s_wait;
                s_wait:  if (bus.burst_done) state <= s_done;
                default: state <= s_idle;             // done pulse lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && (read_do || write_do)) begin
            op_r       <= pick_write ? op_write : op_read;
            waddr_r    <= sel_addr[31:2];
            cnt_r      <= sel_cnt;
            be_first_r <= be_mask[3:0];
            be_last_r  <= sel_be_last;
            wdata_r    <= burst_data_t'(write_data) << {sel_addr[1:0], 3'b000};
            off_r      <= sel_addr[1:0];
            len_r      <= sel_len;
        end
    end

    // --------------------
    // burst side

    assign bus.burst_do     = (state == s_wait);
    assign bus.op           = op_r;
    assign bus.address      = waddr_r;
    assign bus.count        = cnt_r;
    assign bus.byteen_first = be_first_r;
    assign bus.byteen_last  = be_last_r;
    assign bus.wdata        = wdata_r;

    // --------------------
    // read return

    assign shifted  = bus.rdata >> {off_r, 3'b000};                 // first byte to bit 0
    assign len_mask = (read_data_t'(1) << {len_r, 3'b000}) - read_data_t'(1);  // len 8 wraps

    always_ff @(posedge clk) begin
        if (state == s_wait && bus.burst_done && op_r == op_read) begin
            read_data <= shifted[63:0] & len_mask;
        end
    end

    assign read_done  = (state == s_done) && (op_r == op_read);
    assign write_done = (state == s_done) && (op_r == op_write);

endmodule

// ==== burst_link.sv ====
/*
 * Registered link stage on the burst interface
 *   - full copy of the request toward the responder
 *   - full copy of the response toward the requester
 */

`timescale 1ns/10ps

module burst_link import mem_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    burst_if.responder up,
    burst_if.requester down
);

    logic        down_do_r;
    logic        up_done_r;
    logic        busy;
    burst_op_t   op_r;
    word_addr_t  addr_r;
    burst_cnt_t  cnt_r;
    byteen_t     be_first_r;
    byteen_t     be_last_r;
    burst_data_t wdata_r;
    burst_data_t rdata_r;

    assign busy = down_do_r || up_done_r;   // one burst in the stage

    always_ff @(posedge clk) begin
        if (reset) begin
            down_do_r <= 1'b0;
            up_done_r <= 1'b0;
        end else begin
            up_done_r <= 1'b0;
            if (!busy && up.burst_do) down_do_r <= 1'b1;
            if (down_do_r && down.burst_done) begin
                down_do_r <= 1'b0;
                up_done_r <= 1'b1;
            end
        end
    end

    // --------------------
    // payload copies

    always_ff @(posedge clk) begin
        if (!busy && up.burst_do) begin
            op_r       <= up.op;
            addr_r     <= up.address;
            cnt_r      <= up.count;
            be_first_r <= up.byteen_first;
            be_last_r  <= up.byteen_last;
            wdata_r    <= up.wdata;
        end
        if (down.burst_done) rdata_r <= down.rdata;
    end

    assign down.burst_do     = down_do_r;
    assign down.op           = op_r;
    assign down.address      = addr_r;
    assign down.count        = cnt_r;
    assign down.byteen_first = be_first_r;
    assign down.byteen_last  = be_last_r;
    assign down.wdata        = wdata_r;

    assign up.burst_done = up_done_r;
    assign up.rdata      = rdata_r;

endmodule

// ==== avalon_burst_master.sv ====
/*
 * Avalon-MM burst master
 *   - write bursts, one word per accepted beat
 *   - read bursts, one command then count returned words
 *   - per-beat byte enables and read word packing
 */

`timescale 1ns/10ps

module avalon_burst_master import mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    burst_if.responder  cmd,

    output word_addr_t  avm_address,
    output dword_t      avm_writedata,
    output byteen_t     avm_byteenable,
    output logic [3:0]  avm_burstcount,
    output logic        avm_read,
    output logic        avm_write,
    input  logic        avm_waitrequest,
    input  logic        avm_readdatavalid,
    input  dword_t      avm_readdata
);

    avm_state_t  state;
    burst_cnt_t  word_cnt;          // current beat
    burst_cnt_t  last_idx;
    logic        last_word;
    logic        done_r;
    burst_data_t rdata_r;

    assign last_idx  = cmd.count - 2'd1;
    assign last_word = (word_cnt == last_idx);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= a_idle;
            word_cnt <= 2'd0;
            done_r   <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state)
                a_idle: begin
                    if (cmd.burst_do && !done_r) begin   // do still high in the done cycle
                        word_cnt <= 2'd0;
                        if (cmd.op == op_write) state <= a_write;
                        else                    state <= a_read_cmd;
                    end
                end
                a_write: begin
                    if (!avm_waitrequest) begin
                        if (last_word) begin
                            state  <= a_idle;
                            done_r <= 1'b1;
                        end else begin
                            word_cnt <= word_cnt + 2'd1;
                        end
                    end
                end
                a_read_cmd: begin
                    if (!avm_waitrequest) state <= a_read_data;
                end
                default: begin
                    if (avm_readdatavalid) begin
                        if (last_word) begin
                            state  <= a_idle;
                            done_r <= 1'b1;
                        end else begin
                            word_cnt <= word_cnt + 2'd1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == a_read_data && avm_readdatavalid) begin
            rdata_r[{word_cnt, 5'b00000} +: 32] <= avm_readdata;
        end
    end

    // --------------------
    // bus outputs held steady by the link registers

    always_comb begin
        if (word_cnt == 2'd0)  avm_byteenable = cmd.byteen_first;
        else if (last_word)    avm_byteenable = cmd.byteen_last;
        else                   avm_byteenable = 4'b1111;   // middle word
    end

    assign avm_address    = cmd.address;
    assign avm_burstcount = {2'b00, cmd.count};
    assign avm_writedata  = cmd.wdata[{word_cnt, 5'b00000} +: 32];
    assign avm_write      = (state == a_write);
    assign avm_read       = (state == a_read_cmd);

    assign cmd.burst_done = done_r;
    assign cmd.rdata      = rdata_r;

endmodule

// ==== mem_subsys.sv ====
/*
 * Top level of the data-side memory subsystem
 *   - read and write requester ports
 *   - splitter, registered link and Avalon-MM burst master
 */

`timescale 1ns/10ps

module mem_subsys import mem_pkg::*; #(
    parameter bit WRITE_PRIORITY = 1'b1
) (
    input  logic        clk,
    input  logic        reset,

    input  logic        read_do,
    input  addr_t       read_addr,
    input  read_len_t   read_len,
    output logic        read_done,
    output read_data_t  read_data,

    input  logic        write_do,
    input  addr_t       write_addr,
    input  write_len_t  write_len,
    input  dword_t      write_data,
    output logic        write_done,

    output word_addr_t  avm_address,
    output dword_t      avm_writedata,
    output byteen_t     avm_byteenable,
    output logic [3:0]  avm_burstcount,
    output logic        avm_read,
    output logic        avm_write,
    input  logic        avm_waitrequest,
    input  logic        avm_readdatavalid,
    input  dword_t      avm_readdata
);

    burst_if split_if ();           // splitter to link
    burst_if bus_if ();             // link to bus master

    mem_access_split #(
        .WRITE_PRIORITY (WRITE_PRIORITY)
    ) u_split (
        .clk        (clk),
        .reset      (reset),
        .read_do    (read_do),
        .read_addr  (read_addr),
        .read_len   (read_len),
        .read_done  (read_done),
        .read_data  (read_data),
        .write_do   (write_do),
        .write_addr (write_addr),
        .write_len  (write_len),
        .write_data (write_data),
        .write_done (write_done),
        .bus        (split_if.requester)
    );

    burst_link u_link (
        .clk   (clk),
        .reset (reset),
        .up    (split_if.responder),
        .down  (bus_if.requester)
    );

    avalon_burst_master u_avm (
        .clk               (clk),
        .reset             (reset),
        .cmd               (bus_if.responder),
        .avm_address       (avm_address),
        .avm_writedata     (avm_writedata),
        .avm_byteenable    (avm_byteenable),
        .avm_burstcount    (avm_burstcount),
        .avm_read          (avm_read),
        .avm_write         (avm_write),
        .avm_waitrequest   (avm_waitrequest),
        .avm_readdatavalid (avm_readdatavalid),
        .avm_readdata      (avm_readdata)
    );

endmodule

// ==== mem_subsys_checker.sv ====
/*
 * Protocol assertions for the memory subsystem top level
 *   - Avalon read and write never together
 *   - done pulses only while their own do is high
 *   - command held stable under waitrequest
 */

`timescale 1ns/10ps

module mem_subsys_checker (
    input logic        clk,
    input logic        reset,
    input logic        read_do,
    input logic        read_done,
    input logic        write_do,
    input logic        write_done,
    input logic        avm_read,
    input logic        avm_write,
    input logic        avm_waitrequest,
    input logic [29:0] avm_address,
    input logic [3:0]  avm_burstcount,
    input logic [31:0] avm_writedata
);

    int assert_fails = 0;     // failures seen so far

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
        !(avm_read && avm_write))
        else begin assert_fails++; $error("avm_read and avm_write high together"); end

    a_done_excl: assert property (@(posedge clk) disable iff (reset)
        !(read_done && write_done))
        else begin assert_fails++; $error("read_done and write_done high together"); end

    a_read_done_do: assert property (@(posedge clk) disable iff (reset)
        read_done |-> read_do)
        else begin assert_fails++; $error("read_done without read_do"); end

    a_write_done_do: assert property (@(posedge clk) disable iff (reset)
        write_done |-> write_do)
        else begin assert_fails++; $error("write_done without write_do"); end

    // command held while the slave stalls
    a_hold_cmd: assert property (@(posedge clk) disable iff (reset)
        (avm_waitrequest && (avm_read || avm_write)) |=>
            ($stable(avm_address) && $stable(avm_burstcount) && $stable(avm_writedata)))
        else begin assert_fails++; $error("Avalon command changed under waitrequest"); end

endmodule

// ==== tb_mem_subsys.sv ====
/*
 * Testbench for the data-side memory subsystem
 *   - clock, reset and xorshift stimulus
 *   - Avalon-MM slave memory with random waitrequest and readdatavalid gaps
 *   - reference byte array, read and burst command checks
 *   - done counting, memory compare and watchdog
 */

`timescale 1ns/10ps

module tb_mem_subsys import mem_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_TRANS    = 400;
    localparam int TRANS_CYCLES = 60;
    localparam int MEM_BYTES    = 1024;

    logic       clk;
    logic       reset;
    logic       read_do;
    addr_t      read_addr;
    read_len_t  read_len;
    logic       read_done;
    read_data_t read_data;
    logic       write_do;
    addr_t      write_addr;
    write_len_t write_len;
    dword_t     write_data;
    logic       write_done;
    word_addr_t avm_address;
    dword_t     avm_writedata;
    byteen_t    avm_byteenable;
    logic [3:0] avm_burstcount;
    logic       avm_read;
    logic       avm_write;
    logic       avm_waitrequest;
    logic       avm_readdatavalid;
    dword_t     avm_readdata;

    logic [7:0]  mem_bytes [MEM_BYTES];    // slave memory contents
    logic [7:0]  ref_bytes [MEM_BYTES];    // expected contents
    dword_t      rd_words [$];             // read words not yet returned
    word_addr_t  exp_addr_q [$];
    int          exp_cnt_q [$];
    int          wr_beat;
    logic [31:0] drv_rng;
    logic [31:0] bus_rng;
    int          errors = 0;
    int          reads_issued = 0;
    int          writes_issued = 0;
    int          read_done_cnt = 0;
    int          write_done_cnt = 0;

    mem_subsys #(
        .WRITE_PRIORITY (1'b1)
    ) u_mem_subsys (
        .clk (clk), .reset (reset),
        .read_do (read_do), .read_addr (read_addr), .read_len (read_len),
        .read_done (read_done), .read_data (read_data),
        .write_do (write_do), .write_addr (write_addr), .write_len (write_len),
        .write_data (write_data), .write_done (write_done),
        .avm_address (avm_address), .avm_writedata (avm_writedata),
        .avm_byteenable (avm_byteenable), .avm_burstcount (avm_burstcount),
        .avm_read (avm_read), .avm_write (avm_write),
        .avm_waitrequest (avm_waitrequest), .avm_readdatavalid (avm_readdatavalid),
        .avm_readdata (avm_readdata)
    );

    bind mem_subsys mem_subsys_checker u_checker (
        .clk (clk), .reset (reset),
        .read_do (read_do), .read_done (read_done),
        .write_do (write_do), .write_done (write_done),
        .avm_read (avm_read), .avm_write (avm_write),
        .avm_waitrequest (avm_waitrequest), .avm_address (avm_address),
        .avm_burstcount (avm_burstcount), .avm_writedata (avm_writedata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------
    // helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        drv_rng = xorshift32(drv_rng);
        return drv_rng;
    endfunction

    function automatic int span_words(input addr_t addr, input int len);
        return (int'(addr[1:0]) + len + 3) / 4;     // round up to whole words
    endfunction

    function automatic read_data_t predict_read(input addr_t addr, input int len);
        read_data_t r;
        int i;
        r = '0;
        for (i = 0; i < len; i++) r[8*i +: 8] = ref_bytes[addr + i];
        return r;
    endfunction

    task automatic update_ref(input addr_t addr, input int len, input dword_t data);
        int i;
        for (i = 0; i < len; i++) ref_bytes[addr + i] = data[8*i +: 8];
        exp_addr_q.push_back(addr[31:2]);
        exp_cnt_q.push_back(span_words(addr, len));
        writes_issued++;
    endtask

    task automatic check_read(input addr_t addr, input int len);
        read_data_t exp;
        exp = predict_read(addr, len);
        if (read_data !== exp) begin
            errors++;
            $display("FAIL t=%0t read_data got %h expected %h (addr %h len %0d)",
                     $time, read_data, exp, addr, len);
        end
    endtask

    task automatic check_burst_cmd();
        word_addr_t ea;
        int ec;
        if (exp_addr_q.size() == 0) begin
            errors++;
            $display("t=%0t: Avalon command arrived with no request outstanding", $time);
        end else begin
            ea = exp_addr_q.pop_front();
            ec = exp_cnt_q.pop_front();
            if (avm_address !== ea) begin
                errors++;
                $display("FAIL t=%0t avm_address got %h expected %h", $time, avm_address, ea);
            end
            if (avm_burstcount !== 4'(ec)) begin
                errors++;
                $display("FAIL t=%0t avm_burstcount got %0d expected %0d",
                         $time, avm_burstcount, ec);
            end
        end
    endtask

    task automatic issue_write(input addr_t addr, input int len, input dword_t data);
        @(posedge clk);
        write_do   <= 1'b1;
        write_addr <= addr;
        write_len  <= write_len_t'(len);
        write_data <= data;
        update_ref(addr, len, data);
        do @(posedge clk); while (!write_done);
        write_do <= 1'b0;
    endtask

    task automatic issue_read(input addr_t addr, input int len);
        @(posedge clk);
        read_do   <= 1'b1;
        read_addr <= addr;
        read_len  <= read_len_t'(len);
        exp_addr_q.push_back(addr[31:2]);
        exp_cnt_q.push_back(span_words(addr, len));
        reads_issued++;
        do @(posedge clk); while (!read_done);
        read_do <= 1'b0;
        check_read(addr, len);
    endtask

    // write and read raised in the same cycle
    task automatic issue_both(input addr_t waddr, input int wlen, input dword_t wdata,
                              input addr_t raddr, input int rlen);
        logic got_w;
        logic got_r;
        @(posedge clk);
        write_do   <= 1'b1;
        write_addr <= waddr;
        write_len  <= write_len_t'(wlen);
        write_data <= wdata;
        read_do    <= 1'b1;
        read_addr  <= raddr;
        read_len   <= read_len_t'(rlen);
        update_ref(waddr, wlen, wdata);
        exp_addr_q.push_back(raddr[31:2]);
        exp_cnt_q.push_back(span_words(raddr, rlen));
        reads_issued++;
        got_w = 1'b0;
        got_r = 1'b0;
        while (!(got_w && got_r)) begin
            @(posedge clk);
            if (write_done) begin
                got_w = 1'b1;
                write_do <= 1'b0;
            end
            if (read_done) begin
                if (!got_w) begin
                    errors++;
                    $display("t=%0t: read finished before the concurrent write", $time);
                end
                check_read(raddr, rlen);
                got_r = 1'b1;
                read_do <= 1'b0;
            end
        end
    endtask

    // --------------------
    // Avalon slave memory

    always @(posedge clk) begin : avalon_slave
        int b;
        int base;
        bus_rng = xorshift32(bus_rng);
        if (reset) begin
            wr_beat = 0;
            rd_words.delete();
            avm_readdatavalid <= 1'b0;
        end else begin
            if (avm_write && !avm_waitrequest) begin
                if (wr_beat == 0) check_burst_cmd();
                base = (int'(avm_address) + wr_beat) * 4;       // slave counts the beats
                for (b = 0; b < 4; b++) begin
                    if (avm_byteenable[b]) mem_bytes[base + b] = avm_writedata[8*b +: 8];
                end
                wr_beat = (wr_beat + 1 == int'(avm_burstcount)) ? 0 : wr_beat + 1;
            end
            if (avm_read && !avm_waitrequest) begin
                check_burst_cmd();
                for (b = 0; b < int'(avm_burstcount); b++) begin
                    base = (int'(avm_address) + b) * 4;
                    rd_words.push_back({mem_bytes[base + 3], mem_bytes[base + 2],
                                        mem_bytes[base + 1], mem_bytes[base]});
                end
            end
            if (rd_words.size() > 0 && bus_rng[3:2] != 2'b00) begin
                avm_readdatavalid <= 1'b1;
                avm_readdata      <= rd_words.pop_front();
            end else begin
                avm_readdatavalid <= 1'b0;
                avm_readdata      <= bus_rng;               // junk between beats
            end
        end
        avm_waitrequest <= (bus_rng[1:0] == 2'b00);         // stall about one cycle in four
    end

    always @(posedge clk) begin
        if (!reset && read_done) read_done_cnt++;
        if (!reset && write_done) write_done_cnt++;
    end

    initial begin
        #(NUM_TRANS * TRANS_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d ns",
                 NUM_TRANS * TRANS_CYCLES * CLK_PERIOD);
        $display("Test FAILED");
        $finish;
    end

    // --------------------
    // main sequence

    initial begin
        int k;
        int off;
        int len;
        addr_t a;
        dword_t d;
        reset = 1'b1;
        read_do = 1'b0;
        read_addr = '0;
        read_len = '0;
        write_do = 1'b0;
        write_addr = '0;
        write_len = '0;
        write_data = '0;
        avm_waitrequest = 1'b0;
        avm_readdatavalid = 1'b0;
        avm_readdata = '0;
        drv_rng = 32'd91;
        bus_rng = xorshift32(32'd91);
        for (k = 0; k < MEM_BYTES; k++) begin
            mem_bytes[k] = 8'(k * 7) ^ 8'(k >> 8);
            ref_bytes[k] = mem_bytes[k];
        end

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        if ({avm_read, avm_write, read_done, write_done} !== 4'b0000) begin
            errors++;
            $display("FAIL t=%0t avm_read/avm_write/read_done/write_done got %b expected 0000",
                     $time, {avm_read, avm_write, read_done, write_done});
        end

        // aligned words then aligned double words
        for (k = 0; k < 32; k++) issue_write(addr_t'(k * 4), 4, next_rand());
        for (k = 0; k < 16; k++) issue_read(addr_t'(k * 8), 8);

        // unaligned reads over 2 or 3 words
        for (k = 0; k < 60; k++) begin
            a = addr_t'(next_rand() % (MEM_BYTES - 8));
            a[1:0] = 2'(k % 3 + 1);
            len = 1 + int'(next_rand() % 8);
            if (span_words(a, len) < 2) len = 8;
            issue_read(a, len);
        end

        // unaligned writes across a word boundary with a neighbor read back
        for (k = 0; k < 40; k++) begin
            off = 1 + k % 3;
            a = addr_t'((1 + next_rand() % 250) * 4 + off);
            len = 4 - int'(next_rand() % off);
            issue_write(a, len, next_rand());
            issue_read(a - 1, 8);
        end

        // same-cycle read and write on overlapping bytes
        for (k = 0; k < 20; k++) begin
            a = addr_t'(next_rand() % (MEM_BYTES - 16));
            len = 1 + int'(next_rand() % 4);
            d = next_rand();
            issue_both(a, len, d, {a[31:2], 2'b00}, 8);
        end

        // random mix
        for (k = 0; k < 100; k++) begin
            a = addr_t'(next_rand() % (MEM_BYTES - 8));
            if (drv_rng[31]) issue_write(a, 1 + int'(next_rand() % 4), next_rand());
            else             issue_read(a, 1 + int'(next_rand() % 8));
        end

        repeat (10) @(posedge clk);
        for (k = 0; k < MEM_BYTES; k++) begin
            if (mem_bytes[k] !== ref_bytes[k]) begin
                errors++;
                $display("FAIL t=%0t mem_bytes[%0d] got %h expected %h",
                         $time, k, mem_bytes[k], ref_bytes[k]);
            end
        end
        if (read_done_cnt != reads_issued) begin
            errors++;
            $display("FAIL t=%0t read_done count got %0d expected %0d",
                     $time, read_done_cnt, reads_issued);
        end
        if (write_done_cnt != writes_issued) begin
            errors++;
            $display("FAIL t=%0t write_done count got %0d expected %0d",
                     $time, write_done_cnt, writes_issued);
        end
        if (exp_addr_q.size() != 0) begin
            errors++;
            $display("FAIL t=%0t pending burst commands got %0d expected 0",
                     $time, exp_addr_q.size());
        end

        $display("summary: %0d check errors, %0d assertion failures, %0d reads, %0d writes",
                 errors, u_mem_subsys.u_checker.assert_fails, read_done_cnt, write_done_cnt);
        if (errors == 0 && u_mem_subsys.u_checker.assert_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== mem_subsys.f ====
mem_pkg.sv
burst_if.sv
mem_access_split.sv
burst_link.sv
avalon_burst_master.sv
mem_subsys.sv
mem_subsys_checker.sv
tb_mem_subsys.sv
